// ==== logic/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

    typedef logic [7:0]  uart_byte_t;            // One byte on the line
    typedef logic [15:0] div_t;                  // Bit period in clocks
    typedef logic [7:0]  len_t;                  // Payload byte count

    localparam int APB_ADDR_W = 8;               // Host address bus
    localparam int APB_DATA_W = 32;              // Host data bus
    localparam div_t DIV_MIN = 16'd4;            // Shortest legal bit

    // Banner text uudp.start.trans then CR CR LF
    localparam int BANNER_LEN = 19;
    localparam uart_byte_t BANNER [0:BANNER_LEN-1] = '{
        8'h75, 8'h75, 8'h64, 8'h70, 8'h2E, 8'h73, 8'h74, 8'h61,
        8'h72, 8'h74, 8'h2E, 8'h74, 8'h72, 8'h61, 8'h6E, 8'h73,
        8'h0D, 8'h0D, 8'h0A
    };

    localparam logic [APB_ADDR_W-1:0] REG_CTRL    = 8'h00;  // Wr start, rd busy
    localparam logic [APB_ADDR_W-1:0] REG_DIV     = 8'h04;  // Bit period
    localparam logic [APB_ADDR_W-1:0] REG_LEN     = 8'h08;  // Payload length
    localparam logic [APB_ADDR_W-1:0] REG_PAYLOAD = 8'h20;  // First payload slot

endpackage

`default_nettype wire

// ==== logic/uart_cfg_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface uart_cfg_if
    import uart_pkg::*;
#(
    parameter int PAYLOAD_DEPTH = 16
) ();

    logic       start;                           // One cycle go pulse
    len_t       msg_len;                         // Payload bytes after banner
    div_t       divisor;                         // Clocks per bit
    logic       busy;                            // Message in flight

    // Payload buffer write port
    logic                             wr_en;
    logic [$clog2(PAYLOAD_DEPTH)-1:0] wr_index;
    uart_byte_t                       wr_data;

    modport regs_mp (
        output start, msg_len, divisor,
        output wr_en, wr_index, wr_data,
        input  busy
    );

    modport fsm_mp (input start, msg_len, output busy);

    modport buf_mp (input wr_en, wr_index, wr_data);

    modport timer_mp (input divisor);

endinterface

`default_nettype wire

// ==== logic/uart_apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_apb_regs
    import uart_pkg::*;
#(
    parameter int PAYLOAD_DEPTH = 16
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic [APB_DATA_W-1:0] pwdata,
    output logic [APB_DATA_W-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,
    uart_cfg_if.regs_mp           cfg
);

    localparam int   IDX_W     = $clog2(PAYLOAD_DEPTH);
    localparam int   PAY_END   = int'(REG_PAYLOAD) + 4 * PAYLOAD_DEPTH;  // One past last slot
    localparam div_t DIV_RESET = 16'd16;

    logic access;
    logic wr_acc;
    logic sel_ctrl, sel_div, sel_len, sel_pay, mapped;
    logic bad_div, bad_len, bad_start, wr_err, wr_ok;
    logic [APB_ADDR_W-1:0] pay_off;
    div_t div_q;
    len_t len_q;

    ////////////////////////////////////////
    // Address decode and legality

    assign access   = psel & penable;                 // Zero wait access phase
    assign wr_acc   = access & pwrite;
    assign sel_ctrl = (paddr == REG_CTRL);
    assign sel_div  = (paddr == REG_DIV);
    assign sel_len  = (paddr == REG_LEN);
    assign sel_pay  = (paddr[1:0] == 2'b00) && (int'(paddr) >= int'(REG_PAYLOAD))
                      && (int'(paddr) < PAY_END);     // Word aligned slots only
    assign mapped   = sel_ctrl | sel_div | sel_len | sel_pay;
    assign pay_off  = paddr - REG_PAYLOAD;

    assign bad_div   = sel_div && ((pwdata[15:0] < DIV_MIN) || cfg.busy);
    assign bad_len   = sel_len && ((pwdata > APB_DATA_W'(PAYLOAD_DEPTH)) || cfg.busy);
    assign bad_start = sel_ctrl && pwdata[0] && cfg.busy;  // No restart mid message
    assign wr_err    = pwrite && (bad_div || bad_len || bad_start);
    assign wr_ok     = wr_acc && mapped && !wr_err;

    assign pready  = 1'b1;                            // Never stalls
    assign pslverr = access && (!mapped || wr_err);

    ////////////////////////////////////////
    // Config registers

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            div_q <= DIV_RESET;
            len_q <= '0;
        end
        else if (wr_ok)
        begin
            if (sel_div)
                div_q <= pwdata[15:0];
            if (sel_len)
                len_q <= pwdata[7:0];
        end
    end

    assign cfg.divisor = div_q;
    assign cfg.msg_len = len_q;
    assign cfg.start   = wr_ok && sel_ctrl && pwdata[0];   // Pulse lasts the access cycle

    // Payload goes straight to the buffer
    assign cfg.wr_en    = wr_ok && sel_pay;
    assign cfg.wr_index = pay_off[IDX_W+1:2];
    assign cfg.wr_data  = pwdata[7:0];

    // Readback mux, payload slots read zero
    always_comb
    begin
        case (paddr)
            REG_CTRL: prdata = {{(APB_DATA_W-1){1'b0}}, cfg.busy};
            REG_DIV:  prdata = {{(APB_DATA_W-16){1'b0}}, div_q};
            REG_LEN:  prdata = {{(APB_DATA_W-8){1'b0}}, len_q};
            default:  prdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/uart_msg_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_msg_fsm
    import uart_pkg::*;
#(
    parameter int PAYLOAD_DEPTH = 16
) (
    input  logic        clk,
    input  logic        reset,
    uart_cfg_if.fsm_mp  cfg,
    output logic [7:0]  msg_index,
    input  uart_byte_t  msg_byte,
    output logic        byte_valid,
    output uart_byte_t  byte_data,
    input  logic        byte_ready
);

    // Bytes left in the message, banner plus longest payload
    localparam int CNT_W = $clog2(BANNER_LEN + PAYLOAD_DEPTH + 1);

    typedef enum logic [1:0] {
        IDLE,                                   // Waiting for start
        FETCH,                                  // Source lookup in progress
        OFFER,                                  // Byte held for the shifter
        DRAIN                                   // Last frame still on the line
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] remaining;

    ////////////////////////////////////////
    // Sequencer

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= IDLE;
            msg_index <= '0;
            remaining <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (cfg.start)
                    begin
                        msg_index <= '0;              // Banner first
                        remaining <= CNT_W'(BANNER_LEN) + CNT_W'(cfg.msg_len);
                        state     <= FETCH;
                    end
                end
                FETCH:
                    state <= OFFER;                   // Source byte ready next cycle
                OFFER:
                begin
                    if (byte_ready)                   // Handshake done this cycle
                    begin
                        remaining <= remaining - 1'b1;
                        if (remaining == CNT_W'(1))
                            state <= DRAIN;
                        else
                        begin
                            msg_index <= msg_index + 8'd1;
                            state     <= FETCH;
                        end
                    end
                end
                DRAIN:
                begin
                    // Shifter ready again means the last stop bit ended
                    if (byte_ready)
                        state <= IDLE;
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    assign byte_valid = (state == OFFER);
    assign byte_data  = msg_byte;                 // Stable while index holds
    assign cfg.busy   = (state != IDLE);

endmodule

`default_nettype wire

// ==== logic/uart_baud_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_baud_timer
    import uart_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    uart_cfg_if.timer_mp  cfg,
    input  logic          run,
    output logic          bit_tick
);

    div_t cnt;                                  // Clocks into current bit
    logic at_end;

    assign at_end = (cnt == cfg.divisor - 16'd1);

    always_ff @(posedge clk)
    begin
        if (reset)
            cnt <= '0;
        else if (!run)
            cnt <= '0;                          // Parked between frames
        else if (at_end)
            cnt <= '0;                          // Next bit starts
        else
            cnt <= cnt + 16'd1;
    end

    // One tick per bit period, first one divisor cycles after run rose
    assign bit_tick = run && at_end;

endmodule

`default_nettype wire

// ==== logic/uart_tx_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx_shifter
    import uart_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        byte_valid,
    input  uart_byte_t  byte_data,
    output logic        byte_ready,
    output logic        timer_run,
    input  logic        bit_tick,
    output logic        tx
);

    localparam int FRAME_BITS = 10;             // Start, eight data, stop

    logic [FRAME_BITS-1:0] frame;               // Bit 0 is on the line
    logic [3:0]            bit_cnt;             // Ticks seen this frame
    logic                  active;
    logic                  load;

    assign load = byte_valid && !active;

    ////////////////////////////////////////
    // Frame shift register

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            frame   <= '1;                      // Line idles high
            bit_cnt <= '0;
            active  <= 1'b0;
        end
        else if (load)
        begin
            frame   <= {1'b1, byte_data, 1'b0}; // LSB first after start bit
            bit_cnt <= '0;
            active  <= 1'b1;
        end
        else if (active && bit_tick)
        begin
            frame <= {1'b1, frame[FRAME_BITS-1:1]};  // Fill with idle ones
            if (bit_cnt == 4'(FRAME_BITS - 1))
            begin
                // Stop bit done
                bit_cnt <= '0;
                active  <= 1'b0;
            end
            else
                bit_cnt <= bit_cnt + 4'd1;
        end
    end

    assign tx         = frame[0];
    assign timer_run  = active;                 // Timer only counts during a frame
    assign byte_ready = !active;

endmodule

`default_nettype wire

// ==== logic/uart_msg_source.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_msg_source
    import uart_pkg::*;
#(
    parameter int PAYLOAD_DEPTH = 16
) (
    input  logic        clk,
    input  logic        reset,
    uart_cfg_if.buf_mp  cfg,
    input  logic [7:0]  msg_index,
    output uart_byte_t  msg_byte
);

    localparam int IDX_W = $clog2(PAYLOAD_DEPTH);

    uart_byte_t payload [PAYLOAD_DEPTH];        // Host written tail
    logic [7:0] pay_off;                        // Index past the banner

    ////////////////////////////////////////
    // Payload buffer

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < PAYLOAD_DEPTH; i++)
                payload[i] <= '0;
        end
        else if (cfg.wr_en)
            payload[cfg.wr_index] <= cfg.wr_data;
    end

    ////////////////////////////////////////
    // Byte lookup, one cycle latency

    assign pay_off = msg_index - 8'(BANNER_LEN);

    always_ff @(posedge clk)
    begin
        if (msg_index < 8'(BANNER_LEN))
            msg_byte <= BANNER[msg_index[4:0]];         // Fixed banner text
        else
            msg_byte <= payload[pay_off[IDX_W-1:0]];    // Length never exceeds the buffer
    end

endmodule

`default_nettype wire

// ==== logic/uart_msg_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_msg_top
    import uart_pkg::*;
#(
    parameter int PAYLOAD_DEPTH = 16
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic [APB_DATA_W-1:0] pwdata,
    output logic [APB_DATA_W-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  tx,
    output logic                  busy
);

    logic [7:0] msg_index;                      // Sequencer to source
    uart_byte_t msg_byte;
    logic       byte_valid;                     // Sequencer to shifter handshake
    uart_byte_t byte_data;
    logic       byte_ready;
    logic       timer_run;
    logic       bit_tick;

    uart_cfg_if #(.PAYLOAD_DEPTH(PAYLOAD_DEPTH)) cfg_bus ();

    ////////////////////////////////////////
    // Host side

    uart_apb_regs #(.PAYLOAD_DEPTH(PAYLOAD_DEPTH)) u_regs (
        .clk(clk), .reset(reset),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .cfg(cfg_bus.regs_mp)
    );

    ////////////////////////////////////////
    // Message path

    uart_msg_fsm #(.PAYLOAD_DEPTH(PAYLOAD_DEPTH)) u_fsm (
        .clk(clk), .reset(reset), .cfg(cfg_bus.fsm_mp),
        .msg_index(msg_index), .msg_byte(msg_byte),
        .byte_valid(byte_valid), .byte_data(byte_data), .byte_ready(byte_ready)
    );

    uart_msg_source #(.PAYLOAD_DEPTH(PAYLOAD_DEPTH)) u_source (
        .clk(clk), .reset(reset), .cfg(cfg_bus.buf_mp),
        .msg_index(msg_index), .msg_byte(msg_byte)
    );

    uart_baud_timer u_timer (
        .clk(clk), .reset(reset), .cfg(cfg_bus.timer_mp),
        .run(timer_run), .bit_tick(bit_tick)
    );

    uart_tx_shifter u_shifter (
        .clk(clk), .reset(reset),
        .byte_valid(byte_valid), .byte_data(byte_data), .byte_ready(byte_ready),
        .timer_run(timer_run), .bit_tick(bit_tick), .tx(tx)
    );

    assign busy = cfg_bus.busy;                 // Status pin mirrors CTRL bit 0

endmodule

`default_nettype wire

// ==== test/uart_msg_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_msg_tb
    import uart_pkg::*;
();

    localparam int DEPTH      = 16;
    localparam int NUM_CASES  = 3;
    localparam int WAIT_LIMIT = 4000;           // Cycles for busy waits

    // Case table, applied in order
    string case_name [NUM_CASES] = '{"banner_only", "short_payload", "full_payload"};
    int    case_div  [NUM_CASES] = '{4, 7, 16};
    int    case_len  [NUM_CASES] = '{0, 5, 16};
    int    case_seed [NUM_CASES] = '{0, 3, 9};  // Offset on the base seed

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        tx;
    logic        busy;

    uart_byte_t exp_msg [$];                    // Banner then payload
    integer     seed;
    string      banner_text = "uudp.start.trans";

    uart_msg_top #(.PAYLOAD_DEPTH(DEPTH)) DUT (
        .clk(clk), .reset(reset),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .tx(tx), .busy(busy)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;                  // 4 ns period
    end

    ////////////////////////////////////////
    // Checks

    task check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("** Error: %s expected %b actual %b", name, exp, act);
            $display("TESTBENCH FAILED");
            $fatal(1, "bit mismatch");
        end
    endtask

    task check_byte(input string name, input uart_byte_t exp, input uart_byte_t act);
        if (act !== exp)
        begin
            $display("** Error: %s expected 0x%h actual 0x%h", name, exp, act);
            $display("TESTBENCH FAILED");
            $fatal(1, "byte mismatch");
        end
    endtask

    task check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
        begin
            $display("** Error: %s expected %0d actual %0d", name, exp, act);
            $display("TESTBENCH FAILED");
            $fatal(1, "word mismatch");
        end
    endtask

    task report_timeout(input string what);
        $display("Timeout: %s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "wait timed out");
    endtask

    ////////////////////////////////////////
    // APB host, setup then access phase

    task apb_write(input string name, input logic [7:0] addr, input logic [31:0] data,
                   input logic exp_err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        #1;                                     // Settled access phase
        check_bit({name, " pready"}, 1'b1, pready);
        check_bit({name, " pslverr"}, exp_err, pslverr);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task apb_read(input string name, input logic [7:0] addr, input logic [31:0] exp_data,
                  input logic exp_err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #1;
        penable = 1'b1;
        #1;
        check_bit({name, " pslverr"}, exp_err, pslverr);
        check_word({name, " prdata"}, exp_data, prdata);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task wait_busy(input logic level, input string what);
        int   n;
        logic seen;
        seen = 1'b0;
        for (n = 0; n < WAIT_LIMIT && !seen; n++)
        begin
            if (busy === level)
                seen = 1'b1;
            else
                @(negedge clk);
        end
        if (!seen)
            report_timeout(what);
    endtask

    ////////////////////////////////////////
    // Line receiver, sampled on falling clock edges

    task receive_byte(input string name, input int div, output uart_byte_t data);
        int         n;
        int         first_high;
        logic       found;
        logic [9:0] bits;                       // Start, data LSB first, stop
        found = 1'b0;
        for (n = 0; n < 40 * div + 100 && !found; n++)
        begin
            @(negedge clk);
            if (tx === 1'b0)
                found = 1'b1;                   // Start bit edge seen
        end
        if (!found)
            report_timeout({name, ": no start bit arrived on tx"});
        first_high = 0;
        for (n = 1; n <= 9 * div + div / 2; n++)
        begin
            @(negedge clk);
            if (tx === 1'b1 && first_high == 0)
                first_high = n;
            if (n % div == div / 2)
                bits[n / div] = tx;             // Mid-bit sample
        end
        check_bit({name, " start bit"}, 1'b0, bits[0]);
        check_bit({name, " stop bit"}, 1'b1, bits[9]);
        data = bits[8:1];
        // Start bit length visible when bit 0 is high
        if (data[0])
            check_word({name, " bit period"}, 32'(div), 32'(first_high));
    endtask

    task receive_message(input string name, input int div);
        uart_byte_t got;
        for (int i = 0; i < exp_msg.size(); i++)
        begin
            receive_byte($sformatf("%s byte %0d", name, i), div, got);
            check_byte($sformatf("%s byte %0d", name, i), exp_msg[i], got);
        end
        check_bit({name, " busy at last stop"}, 1'b1, busy);  // Still mid stop bit
    endtask

    // Host traffic that must bounce off a running message
    task poke_while_busy(input int c);
        apb_write({case_name[c], " start"}, REG_CTRL, 32'd1, 1'b0);
        wait_busy(1'b1, "busy did not rise after the start write");
        apb_read({case_name[c], " ctrl busy"}, REG_CTRL, 32'd1, 1'b0);
        apb_write({case_name[c], " restart"}, REG_CTRL, 32'd1, 1'b1);
        apb_write({case_name[c], " busy div"}, REG_DIV, 32'd5, 1'b1);
        apb_write({case_name[c], " busy len"}, REG_LEN, 32'd2, 1'b1);
        apb_read({case_name[c], " div held"}, REG_DIV, 32'(case_div[c]), 1'b0);
        apb_read({case_name[c], " len held"}, REG_LEN, 32'(case_len[c]), 1'b0);
    endtask

    ////////////////////////////////////////
    // Main sequence

    initial
    begin
        uart_byte_t pbyte;
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        seed    = 81;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;

        check_bit("reset tx", 1'b1, tx);
        check_bit("reset busy", 1'b0, busy);
        check_bit("reset pslverr", 1'b0, pslverr);
        apb_read("reset div", REG_DIV, 32'd16, 1'b0);
        apb_read("reset ctrl", REG_CTRL, 32'd0, 1'b0);

        // Illegal accesses leave registers alone
        apb_write("div below minimum", REG_DIV, 32'd3, 1'b1);
        apb_read("div unchanged", REG_DIV, 32'd16, 1'b0);
        apb_write("len above depth", REG_LEN, 32'(DEPTH + 1), 1'b1);
        apb_read("len unchanged", REG_LEN, 32'd0, 1'b0);
        apb_write("unmapped write", 8'h0C, 32'd9, 1'b1);   // Legal value for div, len and start
        apb_read("unmapped read", 8'h0C, 32'd0, 1'b1);
        apb_read("div after unmapped", REG_DIV, 32'd16, 1'b0);
        apb_read("len after unmapped", REG_LEN, 32'd0, 1'b0);
        apb_read("ctrl after unmapped", REG_CTRL, 32'd0, 1'b0);

        for (int c = 0; c < NUM_CASES; c++)
        begin
            seed = 81 + case_seed[c];
            apb_write({case_name[c], " set div"}, REG_DIV, 32'(case_div[c]), 1'b0);
            apb_write({case_name[c], " set len"}, REG_LEN, 32'(case_len[c]), 1'b0);
            apb_read({case_name[c], " div readback"}, REG_DIV, 32'(case_div[c]), 1'b0);
            apb_read({case_name[c], " len readback"}, REG_LEN, 32'(case_len[c]), 1'b0);

            exp_msg.delete();
            for (int i = 0; i < banner_text.len(); i++)
                exp_msg.push_back(uart_byte_t'(banner_text[i]));
            exp_msg.push_back(8'h0D);           // CR CR LF
            exp_msg.push_back(8'h0D);
            exp_msg.push_back(8'h0A);
            for (int i = 0; i < case_len[c]; i++)
            begin
                pbyte = 8'($random(seed));
                exp_msg.push_back(pbyte);
                apb_write($sformatf("%s payload %0d", case_name[c], i),
                          REG_PAYLOAD + 8'(4 * i), {24'd0, pbyte}, 1'b0);
            end
            apb_read({case_name[c], " payload reads zero"}, REG_PAYLOAD, 32'd0, 1'b0);

            fork
                receive_message(case_name[c], case_div[c]);
                poke_while_busy(c);
            join
            wait_busy(1'b0, "busy did not fall after the last stop bit");
            check_bit({case_name[c], " tx idle"}, 1'b1, tx);
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
logic/uart_pkg.sv
logic/uart_cfg_if.sv
logic/uart_apb_regs.sv
logic/uart_msg_fsm.sv
logic/uart_baud_timer.sv
logic/uart_tx_shifter.sv
logic/uart_msg_source.sv
logic/uart_msg_top.sv
test/uart_msg_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the UART message testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f list.f --top-module uart_msg_tb -o uart_msg_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/uart_msg_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "^TESTBENCH PASSED$"; then
    exit 0
fi
exit 1
